// ==== logic/board_pkg.sv ====
// =========================================================================
// Opcode and control state types, register map and DAC frame constants
// =========================================================================
`default_nettype none

package board_pkg;

	// Command opcodes carried in the first byte of an SPI transaction
	typedef enum logic [7:0] {
		OP_WRITE = 8'd1,
		OP_READ  = 8'd2,
		OP_DAC   = 8'd3
	} opcode_t;

	// Command decoder states
	typedef enum logic [2:0] {
		ST_OPCODE,
		ST_ADDR,
		ST_DATA,
		ST_DAC_HI,
		ST_DAC_LO,
		ST_SKIP
	} cmd_state_t;

	// Register map seen by the microcontroller
	localparam logic [7:0] ADDR_LED        = 8'd0;
	localparam logic [7:0] ADDR_EXT_CONFIG = 8'd1;
	localparam logic [7:0] ADDR_MISC       = 8'd2;
	localparam logic [7:0] ADDR_STATUS     = 8'd3;
	localparam logic [7:0] ADDR_ID         = 8'd4;

	// Read-only board identification
	localparam logic [7:0] BOARD_ID = 8'hA5;

	// DAC frame is 8 zero command bits then 16 data bits
	localparam int DAC_FRAME_BITS = 24;

endpackage

`default_nettype wire

// ==== logic/mmc_spi_port.sv ====
// =========================================================================
// Mode-0 SPI target, oversampled pins, byte receive and MISO shifter
// =========================================================================
`default_nettype none

module mmc_spi_port (
	input  wire        clk,
	input  wire        rst,
	input  wire        sclk,
	input  wire        csb,
	input  wire        mosi,
	output logic       miso,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	output logic       frame_end,
	input  wire        tx_load,
	input  wire  [7:0] tx_byte
);

	// Pin order in the synchronizer is {csb, sclk, mosi}
	logic [2:0] pin_meta;
	logic [2:0] pin_sync;
	logic       sclk_d;
	logic       csb_d;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       csb_rise;
	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic [7:0] tx_shift;

	// Two-flop synchronizers plus one delay stage for edge detection
	// CSB idles high so it comes out of reset deasserted
	always_ff @(posedge clk) begin
		if (rst) begin
			pin_meta <= 3'b100;
			pin_sync <= 3'b100;
			sclk_d   <= 1'b0;
			csb_d    <= 1'b1;
		end else begin
			pin_meta <= {csb, sclk, mosi};
			pin_sync <= pin_meta;
			sclk_d   <= pin_sync[1];
			csb_d    <= pin_sync[2];
		end
	end

	// SCLK edges only count inside a frame
	assign sclk_rise = pin_sync[1] & ~sclk_d & ~pin_sync[2];
	assign sclk_fall = ~pin_sync[1] & sclk_d & ~pin_sync[2];
	assign csb_rise  = pin_sync[2] & ~csb_d;

	// Bit counter and byte strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt   <= 3'd0;
			rx_valid  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			rx_valid  <= 1'b0;
			frame_end <= csb_rise;
			if (pin_sync[2]) begin
				// Idle between frames
				bit_cnt <= 3'd0;
			end else if (sclk_rise) begin
				bit_cnt  <= bit_cnt + 3'd1;
				rx_valid <= (bit_cnt == 3'd7);
			end
		end
	end

	// MOSI is sampled MSB first on SCLK rise
	always_ff @(posedge clk) begin
		if (sclk_rise) begin
			rx_shift <= {rx_shift[5:0], pin_sync[0]};
			if (bit_cnt == 3'd7)
				rx_byte <= {rx_shift, pin_sync[0]};
		end
	end

	// Transmit side
	// Falling edge at a byte boundary keeps the freshly loaded MSB on MISO
	always_ff @(posedge clk) begin
		if (rst)
			tx_shift <= 8'd0;
		else if (tx_load)
			tx_shift <= tx_byte;
		else if (sclk_rise && bit_cnt == 3'd7)
			tx_shift <= 8'd0;
		else if (sclk_fall && bit_cnt != 3'd0)
			tx_shift <= {tx_shift[6:0], 1'b0};
	end

	assign miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== logic/mmc_command.sv ====
// =========================================================================
// SPI transaction decoder, register access and DAC command dispatch
// =========================================================================
`default_nettype none

module mmc_command import board_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire         rx_valid,
	input  wire  [7:0]  rx_byte,
	input  wire         frame_end,
	output logic        tx_load,
	output logic [7:0]  tx_byte,
	output logic        reg_we,
	output logic        reg_re,
	output logic [7:0]  reg_addr,
	output logic [7:0]  reg_wdata,
	input  wire  [7:0]  reg_rdata,
	output logic        dac_start,
	output logic        dac_sel,
	output logic [15:0] dac_value,
	input  wire         dac_busy
);

	cmd_state_t state;
	opcode_t    opcode;

	// Read data comes straight from the register bank
	// Valid in the cycle tx_load is high since reg_addr is already latched
	assign tx_byte = reg_rdata;

	// Control FSM and strobes
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_OPCODE;
			opcode    <= OP_WRITE;
			reg_we    <= 1'b0;
			reg_re    <= 1'b0;
			tx_load   <= 1'b0;
			dac_start <= 1'b0;
		end else begin
			reg_we    <= 1'b0;
			reg_re    <= 1'b0;
			tx_load   <= 1'b0;
			dac_start <= 1'b0;
			if (frame_end) begin
				// CSB high always ends the transaction
				state <= ST_OPCODE;
			end else if (rx_valid) begin
				case (state)
					ST_OPCODE: begin
						case (rx_byte)
							OP_WRITE, OP_READ, OP_DAC: begin
								opcode <= opcode_t'(rx_byte);
								state  <= ST_ADDR;
							end
							// Unknown opcode, swallow the rest of the frame
							default: state <= ST_SKIP;
						endcase
					end
					ST_ADDR: begin
						case (opcode)
							OP_READ: begin
								// Data shifts out on the following byte
								reg_re  <= 1'b1;
								tx_load <= 1'b1;
								state   <= ST_SKIP;
							end
							OP_WRITE: state <= ST_DATA;
							// DAC select byte
							default: state <= ST_DAC_HI;
						endcase
					end
					ST_DATA: begin
						reg_we <= 1'b1;
						state  <= ST_SKIP;
					end
					ST_DAC_HI: state <= ST_DAC_LO;
					ST_DAC_LO: begin
						// Dropped if a frame is still going out
						dac_start <= ~dac_busy;
						state     <= ST_SKIP;
					end
					// Extra bytes
					default: state <= ST_SKIP;
				endcase
			end
		end
	end

	// Field capture, lined up with the strobes above
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			case (state)
				ST_ADDR: begin
					reg_addr <= rx_byte;
					dac_sel  <= rx_byte[0];
				end
				ST_DATA:   reg_wdata        <= rx_byte;
				ST_DAC_HI: dac_value[15:8]  <= rx_byte;
				ST_DAC_LO: dac_value[7:0]   <= rx_byte;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/config_regs.sv ====
// =========================================================================
// Configuration and status registers, LED and config outputs, interrupt
// =========================================================================
`default_nettype none

module config_regs import board_pkg::*; #(
	parameter logic [7:0] misc_config_default = 8'h00,
	parameter logic [3:0] ext_config_default  = 4'h0
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        reg_we,
	input  wire        reg_re,
	input  wire  [7:0] reg_addr,
	input  wire  [7:0] reg_wdata,
	input  wire        dac_busy,
	input  wire        dac_done,
	output logic [7:0] reg_rdata,
	output logic [7:0] led,
	output logic [3:0] ext_config,
	output logic [7:0] misc,
	output logic       vcxo_en,
	output logic       mmc_int
);

	// Sticky DAC completion flag
	logic done;

	always_ff @(posedge clk) begin
		if (rst) begin
			led        <= 8'd0;
			ext_config <= ext_config_default;
			misc       <= misc_config_default;
			done       <= 1'b0;
		end else begin
			if (reg_we) begin
				case (reg_addr)
					ADDR_LED:        led        <= reg_wdata;
					ADDR_EXT_CONFIG: ext_config <= reg_wdata[3:0];
					ADDR_MISC:       misc       <= reg_wdata;
					// Status, ID and unmapped addresses are read-only
					default: ;
				endcase
			end
			// A new completion wins over a status read in the same cycle
			if (dac_done)
				done <= 1'b1;
			else if (reg_re && reg_addr == ADDR_STATUS)
				done <= 1'b0;
		end
	end

	// Read mux
	always_comb begin
		case (reg_addr)
			ADDR_LED:        reg_rdata = led;
			ADDR_EXT_CONFIG: reg_rdata = {4'd0, ext_config};
			ADDR_MISC:       reg_rdata = misc;
			ADDR_STATUS:     reg_rdata = {6'd0, done, dac_busy};
			ADDR_ID:         reg_rdata = BOARD_ID;
			default:         reg_rdata = 8'd0;
		endcase
	end

	assign mmc_int = done;
	// Bit 1 turns the 20 MHz VCXO off
	assign vcxo_en = ~ext_config[1];

endmodule

`default_nettype wire

// ==== logic/wr_dac_writer.sv ====
// =========================================================================
// Serial writer for 24-bit frames to the two White Rabbit DACs
// =========================================================================
`default_nettype none

module wr_dac_writer import board_pkg::*; #(
	parameter int dac_div = 4
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         dac_start,
	input  wire         dac_sel,
	input  wire  [15:0] dac_value,
	output logic        dac_busy,
	output logic        dac_done,
	output logic        dac_sclk,
	output logic        dac_din,
	output logic        dac1_sync,
	output logic        dac2_sync
);

	// Two SCLK half-periods per bit
	localparam int half_last = 2 * DAC_FRAME_BITS - 1;
	localparam int div_w     = $clog2(dac_div + 1);
	localparam int half_w    = $clog2(half_last + 1);

	logic [div_w-1:0]          div_cnt;
	logic [half_w-1:0]         half_cnt;
	logic [DAC_FRAME_BITS-1:0] shift;
	logic                      half_tick;
	logic                      last_half;
	logic                      frame_over;
	logic                      start_ok;

	assign start_ok  = dac_start & ~dac_busy;
	assign half_tick = (div_cnt == div_w'(dac_div - 1));
	assign last_half = (half_cnt == half_w'(half_last));
	// Line idles low outside a frame
	assign dac_din   = dac_busy & shift[DAC_FRAME_BITS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			dac_busy   <= 1'b0;
			dac_done   <= 1'b0;
			frame_over <= 1'b0;
			dac_sclk   <= 1'b0;
			dac1_sync  <= 1'b1;
			dac2_sync  <= 1'b1;
			div_cnt    <= '0;
			half_cnt   <= '0;
		end else begin
			frame_over <= 1'b0;
			// Done trails the sync rise by one cycle
			dac_done   <= frame_over;
			if (start_ok) begin
				// Sel 0 picks DAC 1
				dac_busy  <= 1'b1;
				dac1_sync <= dac_sel;
				dac2_sync <= ~dac_sel;
				dac_sclk  <= 1'b0;
				div_cnt   <= '0;
				half_cnt  <= '0;
			end else if (dac_busy) begin
				if (half_tick) begin
					div_cnt <= '0;
					if (last_half) begin
						// Final falling edge closes the frame
						dac_busy   <= 1'b0;
						dac_sclk   <= 1'b0;
						dac1_sync  <= 1'b1;
						dac2_sync  <= 1'b1;
						frame_over <= 1'b1;
					end else begin
						half_cnt <= half_cnt + 1'b1;
						dac_sclk <= ~dac_sclk;
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// Data moves on SCLK fall so the DAC sees it stable at the rise
	always_ff @(posedge clk) begin
		if (start_ok)
			shift <= {{(DAC_FRAME_BITS - 16){1'b0}}, dac_value};
		else if (dac_busy && half_tick && dac_sclk)
			shift <= {shift[DAC_FRAME_BITS-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== logic/board_base.sv ====
// =========================================================================
// Board management base, SPI port, command FSM, registers and DAC writer
// =========================================================================
`default_nettype none

module board_base #(
	parameter logic [7:0] misc_config_default = 8'h0c,
	parameter logic [3:0] ext_config_default  = 4'h0,
	parameter int         dac_div             = 4
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        sclk,
	input  wire        csb,
	input  wire        mosi,
	output logic       miso,
	output logic       mmc_int,
	output logic [7:0] led,
	output logic [3:0] ext_config,
	output logic [7:0] misc,
	output logic       vcxo_en,
	output logic       wr_dac_sclk,
	output logic       wr_dac_din,
	output logic       wr_dac1_sync,
	output logic       wr_dac2_sync
);

	// SPI byte interface
	wire        rx_valid;
	wire [7:0]  rx_byte;
	wire        frame_end;
	wire        tx_load;
	wire [7:0]  tx_byte;
	// Register bus
	wire        reg_we;
	wire        reg_re;
	wire [7:0]  reg_addr;
	wire [7:0]  reg_wdata;
	wire [7:0]  reg_rdata;
	// DAC command and status
	wire        dac_start;
	wire        dac_sel;
	wire [15:0] dac_value;
	wire        dac_busy;
	wire        dac_done;

	mmc_spi_port i_spi (
		.clk(clk), .rst(rst), .sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.rx_valid(rx_valid), .rx_byte(rx_byte), .frame_end(frame_end),
		.tx_load(tx_load), .tx_byte(tx_byte)
	);

	mmc_command i_cmd (
		.clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.frame_end(frame_end), .tx_load(tx_load), .tx_byte(tx_byte),
		.reg_we(reg_we), .reg_re(reg_re), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.dac_start(dac_start), .dac_sel(dac_sel), .dac_value(dac_value),
		.dac_busy(dac_busy)
	);

	config_regs #(
		.misc_config_default(misc_config_default),
		.ext_config_default(ext_config_default)
	) i_regs (
		.clk(clk), .rst(rst), .reg_we(reg_we), .reg_re(reg_re),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata),
		.dac_busy(dac_busy), .dac_done(dac_done), .reg_rdata(reg_rdata),
		.led(led), .ext_config(ext_config), .misc(misc),
		.vcxo_en(vcxo_en), .mmc_int(mmc_int)
	);

	wr_dac_writer #(
		.dac_div(dac_div)
	) i_dac (
		.clk(clk), .rst(rst), .dac_start(dac_start), .dac_sel(dac_sel),
		.dac_value(dac_value), .dac_busy(dac_busy), .dac_done(dac_done),
		.dac_sclk(wr_dac_sclk), .dac_din(wr_dac_din),
		.dac1_sync(wr_dac1_sync), .dac2_sync(wr_dac2_sync)
	);

endmodule

`default_nettype wire

// ==== sim/board_base_tb.sv ====
// ==========================================================================
// Testbench for board_base with SPI driver, DAC monitor, reference model
// ==========================================================================
`default_nettype none

module board_base_tb import board_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] misc_def   = 8'h3c;
	// Bit 1 set so vcxo_en starts low
	localparam logic [3:0] ext_def    = 4'h2;
	// Long DAC frame so a second command lands while the first is busy
	localparam int         dac_div    = 32;
	localparam int         frame_clks = 48 * dac_div;
	localparam int         half_clks  = 10;

	logic       clk;
	logic       rst;
	logic       sclk;
	logic       csb;
	logic       mosi;
	logic       miso;
	logic       mmc_int;
	logic [7:0] led;
	logic [3:0] ext_config;
	logic [7:0] misc;
	logic       vcxo_en;
	logic       wr_dac_sclk;
	logic       wr_dac_din;
	logic       wr_dac1_sync;
	logic       wr_dac2_sync;

	// Stimulus state and SPI byte buffers
	logic [15:0] lfsr;
	logic [7:0]  spi_tx [0:7];
	logic [7:0]  spi_rx [0:7];

	// Expected register bank
	logic [7:0] exp_led;
	logic [3:0] exp_ext;
	logic [7:0] exp_misc;
	logic       exp_done;
	logic       exp_busy;

	// Pending checks for the compare process
	string       chk_name_q [$];
	logic [31:0] chk_exp_q [$];
	logic [31:0] chk_act_q [$];
	int          checks = 0;
	int          errors = 0;

	// Frames seen on the DAC pins
	int          mon_sync_q [$];
	int          mon_bits_q [$];
	logic [31:0] mon_data_q [$];
	logic        mon_active;
	logic        mon_sclk_d;
	int          mon_sync;
	int          mon_bits;
	logic [31:0] mon_data;

	board_base #(
		.misc_config_default(misc_def),
		.ext_config_default(ext_def),
		.dac_div(dac_div)
	) i_dut (
		.clk(clk), .rst(rst), .sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.mmc_int(mmc_int), .led(led), .ext_config(ext_config), .misc(misc),
		.vcxo_en(vcxo_en), .wr_dac_sclk(wr_dac_sclk), .wr_dac_din(wr_dac_din),
		.wr_dac1_sync(wr_dac1_sync), .wr_dac2_sync(wr_dac2_sync)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 16'hB400;
			v = {v[14:0], b};
		end
		return v;
	endfunction

	// Register bank model that returns the byte a read shifts out
	// An OP_DAC call marks a finished DAC frame
	function automatic logic [7:0] ref_access(input logic [7:0] op, input logic [7:0] addr,
			input logic [7:0] data);
		logic [7:0] r;
		r = 8'd0;
		if (op == OP_WRITE) begin
			case (addr)
				8'd0: exp_led = data;
				8'd1: exp_ext = data[3:0];
				8'd2: exp_misc = data;
				// Status, ID and unmapped are read-only
				default: ;
			endcase
		end else if (op == OP_READ) begin
			case (addr)
				8'd0: r = exp_led;
				8'd1: r = {4'd0, exp_ext};
				8'd2: r = exp_misc;
				8'd3: begin
					r        = {6'd0, exp_done, exp_busy};
					exp_done = 1'b0;
				end
				8'd4: r = 8'hA5;
				default: r = 8'd0;
			endcase
		end else if (op == OP_DAC) begin
			exp_done = 1'b1;
		end
		return r;
	endfunction

	task automatic post_check(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		chk_name_q.push_back(name);
		chk_exp_q.push_back(exp_v);
		chk_act_q.push_back(act_v);
	endtask

	// Drive point is 1 ns past the rising edge
	task automatic tick(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
		#1;
	endtask

	// Mode 0 with MOSI set half a period ahead and MISO taken at our rising edge
	task automatic spi_frame(input int nbytes);
		csb = 1'b0;
		tick(half_clks);
		for (int b = 0; b < nbytes; b++) begin
			for (int i = 7; i >= 0; i--) begin
				mosi = spi_tx[b][i];
				tick(half_clks);
				spi_rx[b][i] = miso;
				sclk = 1'b1;
				tick(half_clks);
				sclk = 1'b0;
			end
		end
		mosi = 1'b0;
		tick(half_clks);
		csb = 1'b1;
		// Let frame_end get through the synchronizer
		tick(2 * half_clks);
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
		spi_tx[0] = OP_WRITE;
		spi_tx[1] = addr;
		spi_tx[2] = data;
		spi_frame(3);
		void'(ref_access(OP_WRITE, addr, data));
	endtask

	task automatic reg_read_check(input string name, input logic [7:0] addr);
		spi_tx[0] = OP_READ;
		spi_tx[1] = addr;
		spi_tx[2] = 8'd0;
		spi_frame(3);
		post_check(name, ref_access(OP_READ, addr, 8'd0), spi_rx[2]);
	endtask

	task automatic dac_write(input logic [7:0] sel_byte, input logic [15:0] value);
		spi_tx[0] = OP_DAC;
		spi_tx[1] = sel_byte;
		spi_tx[2] = value[15:8];
		spi_tx[3] = value[7:0];
		spi_frame(4);
	endtask

	task automatic check_outputs(input string name);
		post_check({name, " led"}, exp_led, led);
		post_check({name, " ext_config"}, exp_ext, ext_config);
		post_check({name, " misc"}, exp_misc, misc);
		post_check({name, " vcxo_en"}, !exp_ext[1], vcxo_en);
		post_check({name, " mmc_int"}, exp_done, mmc_int);
	endtask

	// Frame is 8 zero bits then the value on the selected sync only
	task automatic check_dac_frame(input string name, input logic sel, input logic [15:0] value);
		if (mon_sync_q.size() == 0) begin
			errors++;
			$display("%s: no DAC frame was seen on either sync line", name);
		end else begin
			post_check({name, " sync line"}, sel ? 2 : 1, mon_sync_q.pop_front());
			post_check({name, " bit count"}, 24, mon_bits_q.pop_front());
			post_check({name, " data"}, {16'd0, value}, mon_data_q.pop_front());
		end
	endtask

	task automatic wait_int(input logic level, input int limit);
		int n;
		n = 0;
		while (mmc_int !== level && n < limit) begin
			tick(1);
			n++;
		end
		if (mmc_int !== level) begin
			$display("Timeout: mmc_int did not reach %0b within %0d cycles", level, limit);
			$display("Finished with errors");
			$finish;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (chk_name_q.size() != 0 && n < limit) begin
			tick(1);
			n++;
		end
		if (chk_name_q.size() != 0) begin
			$display("Timeout: %0d checks were never compared", chk_name_q.size());
			$display("Finished with errors");
			$finish;
		end
	endtask

	// DAC monitor takes DIN on DAC SCLK rise while a sync is low
	always @(posedge clk) begin
		if (rst) begin
			mon_active = 1'b0;
			mon_sclk_d = 1'b0;
		end else begin
			if (!wr_dac1_sync || !wr_dac2_sync) begin
				if (!mon_active) begin
					mon_active = 1'b1;
					mon_bits   = 0;
					mon_data   = '0;
					mon_sync   = !wr_dac1_sync ? 1 : 2;
				end
				// Both low at once is reported as line 3
				if (!wr_dac1_sync && !wr_dac2_sync)
					mon_sync = 3;
				if (wr_dac_sclk && !mon_sclk_d) begin
					mon_data = {mon_data[30:0], wr_dac_din};
					mon_bits++;
				end
			end else if (mon_active) begin
				mon_active = 1'b0;
				mon_sync_q.push_back(mon_sync);
				mon_bits_q.push_back(mon_bits);
				mon_data_q.push_back(mon_data);
			end
			mon_sclk_d = wr_dac_sclk;
		end
	end

	// Compare process
	always @(posedge clk) begin
		string       name;
		logic [31:0] e;
		logic [31:0] a;
		while (chk_name_q.size() != 0) begin
			name = chk_name_q.pop_front();
			e    = chk_exp_q.pop_front();
			a    = chk_act_q.pop_front();
			checks++;
			if (a !== e) begin
				errors++;
				$display("FAILED %s: expected %h, actual %h", name, e, a);
			end
		end
	end

	initial begin
		logic [7:0]  addr;
		logic [7:0]  data;
		logic [7:0]  sel_byte;
		logic [7:0]  sel2_byte;
		logic [15:0] value;
		logic [15:0] value2;
		rst      = 1'b1;
		sclk     = 1'b0;
		csb      = 1'b1;
		mosi     = 1'b0;
		lfsr     = 16'd43;
		exp_led  = 8'd0;
		exp_ext  = ext_def;
		exp_misc = misc_def;
		exp_done = 1'b0;
		exp_busy = 1'b0;
		tick(16);
		rst = 1'b0;
		tick(4);

		// Reset state
		check_outputs("reset");
		post_check("reset dac1 sync", 1, wr_dac1_sync);
		post_check("reset dac2 sync", 1, wr_dac2_sync);
		post_check("reset dac sclk", 0, wr_dac_sclk);
		post_check("reset dac din", 0, wr_dac_din);
		post_check("reset miso", 0, miso);
		reg_read_check("read id", ADDR_ID);

		// Random writes with read-back of each register three times
		for (int k = 0; k < 9; k++) begin
			case (k % 3)
				0: addr = ADDR_LED;
				1: addr = ADDR_EXT_CONFIG;
				default: addr = ADDR_MISC;
			endcase
			data = 8'(rand_bits(8));
			reg_write(addr, data);
			check_outputs("write");
			reg_read_check("read back", addr);
		end

		// Unmapped and read-only addresses
		reg_write(8'h05, 8'(rand_bits(8)));
		reg_write(8'h80, 8'(rand_bits(8)));
		reg_write(ADDR_ID, 8'h00);
		reg_write(ADDR_STATUS, 8'hff);
		check_outputs("unmapped write");
		reg_read_check("read unmapped 05", 8'h05);
		reg_read_check("read unmapped 80", 8'h80);
		reg_read_check("read id after write", ADDR_ID);
		reg_read_check("read idle status", ADDR_STATUS);

		// Unknown opcodes shaped like a LED write
		spi_tx[0] = 8'hc3;
		spi_tx[1] = ADDR_LED;
		spi_tx[2] = ~exp_led;
		spi_frame(3);
		spi_tx[0] = 8'h00;
		spi_frame(3);
		check_outputs("unknown opcode");

		// Trailing bytes after a complete write and a complete read
		data      = 8'(rand_bits(8));
		spi_tx[0] = OP_WRITE;
		spi_tx[1] = ADDR_MISC;
		spi_tx[2] = data;
		spi_tx[3] = OP_WRITE;
		spi_tx[4] = ADDR_LED;
		spi_tx[5] = ~exp_led;
		spi_frame(6);
		void'(ref_access(OP_WRITE, ADDR_MISC, data));
		check_outputs("extra write bytes");
		spi_tx[0] = OP_READ;
		spi_tx[1] = ADDR_LED;
		spi_tx[2] = 8'd0;
		spi_tx[3] = OP_WRITE;
		spi_tx[4] = ADDR_LED;
		spi_tx[5] = ~exp_led;
		spi_frame(6);
		post_check("extra read bytes", ref_access(OP_READ, ADDR_LED, 8'd0), spi_rx[2]);
		check_outputs("extra read bytes");

		// DAC frames with interrupt and status clear
		for (int k = 0; k < 4; k++) begin
			// Select alternates between the two DACs while the upper bits stay random
			sel_byte = {7'(rand_bits(7)), k[0]};
			value    = rand_bits(16);
			dac_write(sel_byte, value);
			wait_int(1'b1, frame_clks + 200);
			tick(2);
			check_dac_frame("dac", sel_byte[0], value);
			void'(ref_access(OP_DAC, 8'd0, 8'd0));
			check_outputs("dac done");
			reg_read_check("status after dac", ADDR_STATUS);
			reg_read_check("status cleared", ADDR_STATUS);
			check_outputs("int cleared");
		end

		// Second command while the first frame is still shifting
		sel_byte  = 8'(rand_bits(8));
		value     = rand_bits(16);
		sel2_byte = 8'(rand_bits(8));
		value2    = rand_bits(16);
		dac_write(sel_byte, value);
		exp_busy = 1'b1;
		dac_write(sel2_byte, value2);
		reg_read_check("status while busy", ADDR_STATUS);
		exp_busy = 1'b0;
		wait_int(1'b1, frame_clks + 200);
		// Room for a dropped frame to show up
		tick(frame_clks + 100);
		check_dac_frame("busy dac", sel_byte[0], value);
		post_check("frames after dropped dac", 0, mon_sync_q.size());
		void'(ref_access(OP_DAC, 8'd0, 8'd0));
		reg_read_check("status after busy dac", ADDR_STATUS);
		check_outputs("final");

		tick(2);
		wait_drain(100);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/board_pkg.sv
logic/mmc_spi_port.sv
logic/mmc_command.sv
logic/config_regs.sv
logic/wr_dac_writer.sv
logic/board_base.sv
sim/board_base_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board_base testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module board_base_tb -Mdir obj_dir -o board_base_tb
./obj_dir/board_base_tb > sim.log
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
